/* compile.f */
+incdir+include
hw/ecc_mem_pkg.sv
hw/secded_enc.sv
hw/secded_dec.sv
hw/sram_bank.sv
hw/ecc_scrubber.sv
hw/ecc_mem_top.sv
testbench/tb_ecc_mem_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the ECC memory testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ecc_mem_top -f compile.f

# Result is judged from the log and not from the exit status
./obj_dir/Vtb_ecc_mem_top > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  echo "Simulation reported errors"
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi

/* testbench/tb_ecc_mem_top.sv */
// ECC memory testbench with random traffic, fault injection, scrub passes and a reference model

`timescale 1ns/1ns
`default_nettype none

`include "ecc_mem_consts.svh"

module tb_ecc_mem_top;

  import ecc_mem_pkg::*;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   req_i;
  logic                   we_i;
  logic [`ECC_ADDR_W-1:0] addr_i;
  logic [`ECC_DATA_W-1:0] wdata_i;
  logic [`ECC_CODE_W-1:0] inj_mask_i;
  logic [`ECC_DATA_W-1:0] rdata_o;
  ecc_err_t               rd_err_o;
  logic                   scrub_en_i;
  logic                   scrub_corrected_o;
  logic                   scrub_uncorrectable_o;

  // Reference model with data and injected bit count per word
  logic [`ECC_DATA_W-1:0] model_data [`ECC_BANK_WORDS];
  int                     model_cnt  [`ECC_BANK_WORDS];
  // Bit counts taken just before a scrub pass
  int                     pre_cnt    [`ECC_BANK_WORDS];

  integer seed;
  int     errors;
  int     warnings;
  // Scrub events seen by the monitor
  int     n_corr;
  int     n_uncorr;
  int     n_done;

  ecc_mem_top ecc_mem_top_i (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (req_i),
    .we_i                  (we_i),
    .addr_i                (addr_i),
    .wdata_i               (wdata_i),
    .inj_mask_i            (inj_mask_i),
    .rdata_o               (rdata_o),
    .rd_err_o              (rd_err_o),
    .scrub_en_i            (scrub_en_i),
    .scrub_corrected_o     (scrub_corrected_o),
    .scrub_uncorrectable_o (scrub_uncorrectable_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Mid-cycle monitor, pulses are settled here
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (scrub_corrected_o) begin
        n_corr++;
        // Stored word is clean again after the write-back
        model_cnt[ecc_mem_top_i.scrubber_i.working_addr_q] = 0;
      end
      if (scrub_uncorrectable_o) begin
        n_uncorr++;
      end
      // Address step marks the end of one scrubbed word
      if (ecc_mem_top_i.scrubber_i.working_addr_d !=
          ecc_mem_top_i.scrubber_i.working_addr_q) begin
        n_done++;
      end
    end
  end

  // Advance to just after the next rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  // Mask with zero, one or two distinct codeword bits set
  function automatic logic [`ECC_CODE_W-1:0] make_mask(input int nbits);
    logic [`ECC_CODE_W-1:0] m;
    int                     a;
    int                     b;
    m = '0;
    a = rand_below(`ECC_CODE_W);
    b = (a + 1 + rand_below(`ECC_CODE_W - 1)) % `ECC_CODE_W;
    if (nbits >= 1) begin
      m[a] = 1'b1;
    end
    if (nbits >= 2) begin
      m[b] = 1'b1;
    end
    return m;
  endfunction

  task automatic write_word(input logic [`ECC_ADDR_W-1:0] addr,
                            input logic [`ECC_DATA_W-1:0] data, input int nbits);
    req_i      = 1'b1;
    we_i       = 1'b1;
    addr_i     = addr;
    wdata_i    = data;
    inj_mask_i = make_mask(nbits);
    model_data[addr] = data;
    model_cnt[addr]  = nbits;
    next_cycle();
    req_i      = 1'b0;
    we_i       = 1'b0;
    inj_mask_i = '0;
  endtask

  // Client read checked in the cycle after the request
  task automatic read_check(input logic [`ECC_ADDR_W-1:0] addr, input int exp_cnt);
    ecc_err_t exp_err;
    req_i  = 1'b1;
    we_i   = 1'b0;
    addr_i = addr;
    next_cycle();
    req_i = 1'b0;
    // One flipped bit is repaired, two are only flagged
    if (exp_cnt == 0) begin
      exp_err = 2'b00;
    end else if (exp_cnt == 1) begin
      exp_err = 2'b01;
    end else begin
      exp_err = 2'b10;
    end
    assert (rd_err_o == exp_err) else begin
      errors++;
      $display("[FAIL] %0t: addr %0d status %b, expected %b", $time, addr, rd_err_o, exp_err);
    end
    if (exp_cnt < 2) begin
      assert (rdata_o == model_data[addr]) else begin
        errors++;
        $display("[FAIL] %0t: addr %0d data %h, expected %h",
                 $time, addr, rdata_o, model_data[addr]);
      end
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d  Warnings: %0d", errors, warnings);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // Hold scrubbing on until every word has been visited once
  task automatic run_scrub_pass(input int limit);
    int start;
    int cyc;
    start      = n_done;
    cyc        = 0;
    scrub_en_i = 1'b1;
    while ((n_done - start) < `ECC_BANK_WORDS && cyc < limit) begin
      next_cycle();
      cyc++;
    end
    scrub_en_i = 1'b0;
    if ((n_done - start) < `ECC_BANK_WORDS) begin
      errors++;
      $display("Timeout: scrub pass saw %0d of %0d words in %0d cycles",
               n_done - start, `ECC_BANK_WORDS, limit);
    end
  endtask

  initial begin
    int a;
    int kind;
    int singles;
    int doubles;
    int c0;
    int u0;
    int d0;
    seed       = 32'ha42786b7;
    errors     = 0;
    warnings   = 0;
    n_corr     = 0;
    n_uncorr   = 0;
    n_done     = 0;
    rst_ni     = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    inj_mask_i = '0;
    scrub_en_i = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    next_cycle();

    // Clean traffic over a fully written bank
    for (int i = 0; i < `ECC_BANK_WORDS; i++) begin
      write_word(`ECC_ADDR_W'(i), $random(seed), 0);
    end
    for (int i = 0; i < 64; i++) begin
      a = rand_below(`ECC_BANK_WORDS);
      read_check(`ECC_ADDR_W'(a), model_cnt[a]);
    end
    // Write-read pairs, clean then one bit then two bits
    for (int n = 0; n < 3; n++) begin
      for (int i = 0; i < 32; i++) begin
        a = rand_below(`ECC_BANK_WORDS);
        write_word(`ECC_ADDR_W'(a), $random(seed), n);
        read_check(`ECC_ADDR_W'(a), n);
      end
    end

    // Random mix of clean, single and double words for a quiet pass
    singles = 0;
    doubles = 0;
    for (int i = 0; i < `ECC_BANK_WORDS; i++) begin
      kind = rand_below(3);
      write_word(`ECC_ADDR_W'(i), $random(seed), kind);
      pre_cnt[i] = kind;
      if (kind == 1) begin
        singles++;
      end else if (kind == 2) begin
        doubles++;
      end
    end
    c0 = n_corr;
    u0 = n_uncorr;
    run_scrub_pass(3000);
    assert (n_corr - c0 == singles) else begin
      errors++;
      $display("[FAIL] %0t: %0d corrected pulses, expected %0d", $time, n_corr - c0, singles);
    end
    assert (n_uncorr - u0 == doubles) else begin
      errors++;
      $display("[FAIL] %0t: %0d uncorrectable pulses, expected %0d",
               $time, n_uncorr - u0, doubles);
    end
    // Repaired words now read clean, double errors stay flagged
    for (int i = 0; i < `ECC_BANK_WORDS; i++) begin
      read_check(`ECC_ADDR_W'(i), (pre_cnt[i] == 2) ? 2 : 0);
    end

    // Client traffic with the scrubber running underneath
    d0         = n_done;
    scrub_en_i = 1'b1;
    for (int i = 0; i < 600; i++) begin
      kind = rand_below(8);
      a    = rand_below(`ECC_BANK_WORDS);
      if (kind < 3) begin
        next_cycle();
      end else if (kind < 5) begin
        read_check(`ECC_ADDR_W'(a), model_cnt[a]);
      end else begin
        write_word(`ECC_ADDR_W'(a), $random(seed), kind - 5);
      end
    end
    if (n_done == d0) begin
      warnings++;
      $display("Warning: scrubber finished no word during client traffic");
    end
    run_scrub_pass(3000);
    for (int i = 0; i < `ECC_BANK_WORDS; i++) begin
      read_check(`ECC_ADDR_W'(i), model_cnt[i]);
      assert (rd_err_o != 2'b01) else begin
        errors++;
        $display("[FAIL] %0t: addr %0d still correctable after a full pass", $time, i);
      end
    end

    finish_run();
  end

endmodule

`default_nettype wire

/* hw/ecc_mem_top.sv */
// Top level of the ECC memory with encoder, injection XOR, scrubber, bank and read decoder

`timescale 1ns/1ns
`default_nettype none

`include "ecc_mem_consts.svh"

module ecc_mem_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Client port
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [`ECC_ADDR_W-1:0] addr_i,
  input  logic [`ECC_DATA_W-1:0] wdata_i,
  input  logic [`ECC_CODE_W-1:0] inj_mask_i,
  output logic [`ECC_DATA_W-1:0] rdata_o,
  output ecc_mem_pkg::ecc_err_t  rd_err_o,

  // Scrub control
  input  logic                   scrub_en_i,
  output logic                   scrub_corrected_o,
  output logic                   scrub_uncorrectable_o
);

  import ecc_mem_pkg::*;

  // Encoded client word and the word after injection
  ecc_word_u              enc_code;
  ecc_word_u              wr_code;

  // Bank port after arbitration
  logic                   bank_req;
  logic                   bank_we;
  logic [`ECC_ADDR_W-1:0] bank_addr;
  ecc_word_u              bank_wdata;
  ecc_word_u              bank_rdata;

  secded_enc enc_i (
    .data_i (wdata_i),
    .code_o (enc_code)
  );

  // Test-mode fault injection on the raw codeword
  assign wr_code.raw = enc_code.raw ^ inj_mask_i;

  ecc_scrubber scrubber_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scrub_en_i      (scrub_en_i),
    .corrected_o     (scrub_corrected_o),
    .uncorrectable_o (scrub_uncorrectable_o),
    .intc_req_i      (req_i),
    .intc_we_i       (we_i),
    .intc_addr_i     (addr_i),
    .intc_wdata_i    (wr_code),
    .bank_req_o      (bank_req),
    .bank_we_o       (bank_we),
    .bank_addr_o     (bank_addr),
    .bank_wdata_o    (bank_wdata),
    .bank_rdata_i    (bank_rdata)
  );

  sram_bank bank_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (bank_req),
    .we_i    (bank_we),
    .addr_i  (bank_addr),
    .wdata_i (bank_wdata),
    .rdata_o (bank_rdata)
  );

  // Read path decoder valid the cycle after a client read
  secded_dec rd_dec_i (
    .code_i (bank_rdata),
    .code_o (),
    .data_o (rdata_o),
    .err_o  (rd_err_o)
  );

endmodule

`default_nettype wire

/* hw/ecc_scrubber.sv */
// Background scrub FSM with its decoder and client-first bank arbitration

`timescale 1ns/1ns
`default_nettype none

`include "ecc_mem_consts.svh"

module ecc_scrubber (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Scrub control and result pulses
  input  logic                   scrub_en_i,
  output logic                   corrected_o,
  output logic                   uncorrectable_o,

  // Client side of the bank
  input  logic                   intc_req_i,
  input  logic                   intc_we_i,
  input  logic [`ECC_ADDR_W-1:0] intc_addr_i,
  input  ecc_mem_pkg::ecc_word_u intc_wdata_i,

  // Bank side
  output logic                   bank_req_o,
  output logic                   bank_we_o,
  output logic [`ECC_ADDR_W-1:0] bank_addr_o,
  output ecc_mem_pkg::ecc_word_u bank_wdata_o,
  input  ecc_mem_pkg::ecc_word_u bank_rdata_i
);

  import ecc_mem_pkg::*;

  // FSM encoding
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_read  = 2'd1;
  localparam logic [1:0] st_write = 2'd2;

  // Last address before wrapping
  localparam logic [`ECC_ADDR_W-1:0] addr_last = `ECC_ADDR_W'(`ECC_BANK_WORDS - 1);

  logic [1:0]             state_d;
  logic [1:0]             state_q;
  logic [`ECC_ADDR_W-1:0] working_addr_d;
  logic [`ECC_ADDR_W-1:0] working_addr_q;
  logic [`ECC_ADDR_W-1:0] addr_next;

  // Bank access wanted by the scrubber
  logic                   scrub_req;
  logic                   scrub_we;

  // Scrubber owns the bank this cycle
  logic                   scrub_active;

  // Decoded scrub word
  ecc_word_u              scrub_fix;
  ecc_err_t               scrub_err;

  // Repairs the word read in the Read state
  secded_dec scrub_dec_i (
    .code_i (bank_rdata_i),
    .code_o (scrub_fix),
    .data_o (),
    .err_o  (scrub_err)
  );

  // Next address modulo bank size
  assign addr_next = (working_addr_q == addr_last) ? '0 : working_addr_q + 1'b1;

  // Client wins whenever it requests
  assign scrub_active = ((state_q == st_read) || (state_q == st_write)) && !intc_req_i;

  always_comb begin
    // Client drives the bank by default
    bank_req_o   = intc_req_i;
    bank_we_o    = intc_we_i;
    bank_addr_o  = intc_addr_i;
    bank_wdata_o = intc_wdata_i;
    if (scrub_active) begin
      bank_req_o   = scrub_req;
      bank_we_o    = scrub_we;
      bank_addr_o  = working_addr_q;
      bank_wdata_o = scrub_fix;
    end
  end

  always_comb begin
    state_d         = state_q;
    working_addr_d  = working_addr_q;
    scrub_req       = 1'b0;
    scrub_we        = 1'b0;
    corrected_o     = 1'b0;
    uncorrectable_o = 1'b0;
    case (state_q)
      st_idle: begin
        if (scrub_en_i) begin
          state_d = st_read;
        end
      end
      st_read: begin
        // Read only goes out on a cycle the client leaves free
        scrub_req = 1'b1;
        if (!intc_req_i) begin
          state_d = st_write;
        end
      end
      st_write: begin
        if (scrub_err[0]) begin
          // Write back the repaired codeword
          scrub_req = 1'b1;
          scrub_we  = 1'b1;
          if (intc_req_i) begin
            // Slot taken so re-read in case the client changed the word
            state_d = st_read;
          end else begin
            corrected_o    = 1'b1;
            working_addr_d = addr_next;
            state_d        = st_idle;
          end
        end else begin
          // Clean or beyond repair so just move on
          uncorrectable_o = scrub_err[1];
          working_addr_d  = addr_next;
          state_d         = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= st_idle;
      working_addr_q <= '0;
    end else begin
      state_q        <= state_d;
      working_addr_q <= working_addr_d;
    end
  end

  // Client access reaches the bank unchanged so no scrub write lands under it
  a_scrub_write_no_client: assert property (@(posedge clk_i) disable iff (!rst_ni)
    intc_req_i |-> bank_req_o && (bank_we_o == intc_we_i) && (bank_addr_o == intc_addr_i)
                   && (bank_wdata_o == intc_wdata_i));

  // Decoder flags must stay exclusive
  a_pulse_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(corrected_o && uncorrectable_o));

  // Working address never leaves the bank
  a_addr_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    working_addr_q < `ECC_BANK_WORDS);

endmodule

`default_nettype wire

/* hw/sram_bank.sv */
// Bank storage of 256 codewords with synchronous write and registered read

`timescale 1ns/1ns
`default_nettype none

`include "ecc_mem_consts.svh"

module sram_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [`ECC_ADDR_W-1:0] addr_i,
  input  ecc_mem_pkg::ecc_word_u wdata_i,
  output ecc_mem_pkg::ecc_word_u rdata_o
);

  import ecc_mem_pkg::*;

  // Storage array
  ecc_word_u mem_q [0:`ECC_BANK_WORDS-1];

  // Read data register
  ecc_word_u rdata_q;

  // Write lands at the edge closing the request cycle
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // Read word appears one cycle after the request
  // Register holds its value between reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* hw/secded_dec.sv */
// Hsiao SECDED decoder with syndrome, single-bit correction and error flags

`timescale 1ns/1ns
`default_nettype none

`include "ecc_mem_consts.svh"

module secded_dec (
  input  ecc_mem_pkg::ecc_word_u code_i,
  output ecc_mem_pkg::ecc_word_u code_o,
  output logic [`ECC_DATA_W-1:0] data_o,
  output ecc_mem_pkg::ecc_err_t  err_o
);

  import ecc_mem_pkg::*;

  // Syndrome over the whole raw codeword
  logic [`ECC_PROT_W-1:0] syndrome;
  // One-hot position of the bit to repair
  logic [`ECC_CODE_W-1:0] flip;
  // Syndrome matched a column
  logic                   hit;
  // Codeword after repair
  ecc_word_u              corrected;

  // H matrix column of codeword bit k
  // Check bits carry unit columns
  function automatic logic [`ECC_PROT_W-1:0] code_col(int unsigned k);
    if (k < `ECC_DATA_W) begin
      return hsiao_cols[k];
    end
    return `ECC_PROT_W'(1) << (k - `ECC_DATA_W);
  endfunction

  always_comb begin
    // Sum the columns of all set bits
    syndrome = '0;
    for (int unsigned k = 0; k < `ECC_CODE_W; k++) begin
      if (code_i.raw[k]) begin
        syndrome = syndrome ^ code_col(k);
      end
    end
  end

  always_comb begin
    // Zero syndrome matches no column so a clean word passes untouched
    for (int unsigned k = 0; k < `ECC_CODE_W; k++) begin
      flip[k] = (syndrome == code_col(k));
    end
  end

  assign hit = |flip;

  // Repair on the raw view
  assign corrected.raw = code_i.raw ^ flip;

  assign code_o = corrected;

  // Data field of the repaired word
  assign data_o = corrected.fields.data;

  // Nonzero syndrome off every column means two or more flipped bits
  assign err_o[0] = hit;
  assign err_o[1] = (syndrome != '0) && !hit;

endmodule

`default_nettype wire

/* hw/secded_enc.sv */
// Hsiao SECDED encoder forming a 39-bit codeword from a 32-bit data word

`timescale 1ns/1ns
`default_nettype none

`include "ecc_mem_consts.svh"

module secded_enc (
  input  logic [`ECC_DATA_W-1:0] data_i,
  output ecc_mem_pkg::ecc_word_u code_o
);

  import ecc_mem_pkg::*;

  // Check bits before packing
  logic [`ECC_PROT_W-1:0] check;

  always_comb begin
    // One parity sum per matrix row
    for (int i = 0; i < `ECC_PROT_W; i++) begin
      check[i] = 1'b0;
      // Data bit j joins row i when its column has bit i set
      for (int j = 0; j < `ECC_DATA_W; j++) begin
        check[i] = check[i] ^ (data_i[j] & hsiao_cols[j][i]);
      end
    end
  end

  always_comb begin
    // Check bits sit above the data in the codeword
    code_o.fields.check = check;
    code_o.fields.data  = data_i;
  end

endmodule

`default_nettype wire

/* hw/ecc_mem_pkg.sv */
// Codeword union, error status type and Hsiao column table of the ECC memory

`default_nettype none

`include "ecc_mem_consts.svh"

package ecc_mem_pkg;

  // One stored word seen as raw bits or as check and data fields
  typedef union packed {
    logic [`ECC_CODE_W-1:0] raw;
    struct packed {
      logic [`ECC_PROT_W-1:0] check;
      logic [`ECC_DATA_W-1:0] data;
    } fields;
  } ecc_word_u;

  // Bit 0 flags a correctable error and bit 1 an uncorrectable one
  typedef logic [1:0] ecc_err_t;

  // Data columns of the H matrix
  // Distinct weight-3 vectors taken in ascending order
  function automatic logic [`ECC_DATA_W-1:0][`ECC_PROT_W-1:0] gen_hsiao_cols();
    logic [`ECC_DATA_W-1:0][`ECC_PROT_W-1:0] cols;
    logic [`ECC_PROT_W-1:0]                  cand;
    int unsigned                             n;
    cols = '0;
    n    = 0;
    for (int v = 0; v < (1 << `ECC_PROT_W); v++) begin
      cand = `ECC_PROT_W'(v);
      if ($countones(cand) == 3 && n < `ECC_DATA_W) begin
        cols[n] = cand;
        n       = n + 1;
      end
    end
    return cols;
  endfunction

  // Odd-weight columns keep double errors apart from single ones
  localparam logic [`ECC_DATA_W-1:0][`ECC_PROT_W-1:0] hsiao_cols = gen_hsiao_cols();

endpackage

`default_nettype wire

/* include/ecc_mem_consts.svh */
// Size constants for the ECC memory bank and its 39/32 SECDED code

`ifndef ECC_MEM_CONSTS_SVH
`define ECC_MEM_CONSTS_SVH

// Number of words held in the bank
`define ECC_BANK_WORDS 256

// Word address width
`define ECC_ADDR_W 8

// Client data width
`define ECC_DATA_W 32

// Hsiao check bits per word
`define ECC_PROT_W 7

// Stored codeword width is data plus check bits
`define ECC_CODE_W 39

`endif
